// ==== hw/exec_pkg.sv ====
`default_nettype none

package exec_pkg;

        // ==========================================================
        // widths and reset values
        // ==========================================================
        localparam int xlen      = 32;
        localparam int reg_idx_w = 5;

        localparam logic [xlen-1:0] pc_rst = 32'h8000_0000;

        // ==========================================================
        // operation encodings
        // ==========================================================
        typedef enum logic [3:0] {
                alu_add  = 4'd0,
                alu_sub  = 4'd1,
                alu_slt  = 4'd2,
                alu_sltu = 4'd3,
                alu_or   = 4'd4,
                alu_and  = 4'd5,
                alu_xor  = 4'd6,
                alu_sll  = 4'd7,
                alu_srl  = 4'd8,
                alu_sra  = 4'd9
        } alu_op_t;

        typedef enum logic {
                src1_rs1 = 1'b0,
                src1_pc  = 1'b1
        } src1_sel_t;

        typedef enum logic [1:0] {
                src2_rs2  = 2'd0,
                src2_imm  = 2'd1,
                src2_four = 2'd2
        } src2_sel_t;

        // nine conditions, so four bits
        typedef enum logic [3:0] {
                br_none = 4'd0,
                br_eq   = 4'd1,
                br_ne   = 4'd2,
                br_lt   = 4'd3,
                br_ge   = 4'd4,
                br_ltu  = 4'd5,
                br_geu  = 4'd6,
                br_jal  = 4'd7,
                br_jalr = 4'd8
        } br_cond_t;

        // ==========================================================
        // stage payloads
        // ==========================================================
        typedef struct packed {
                logic                 valid;
                logic [xlen-1:0]      pc;
                logic [reg_idx_w-1:0] rd;
                logic                 write_rd;
                logic [xlen-1:0]      imm;
                logic [xlen-1:0]      rs1_data;
                logic [xlen-1:0]      rs2_data;
                alu_op_t              alu_op;
                src1_sel_t            src1_sel;
                src2_sel_t            src2_sel;
                br_cond_t             br_cond;
        } idex_t;

        typedef struct packed {
                logic                 valid;
                logic [xlen-1:0]      pc;
                logic [reg_idx_w-1:0] rd;
                logic                 write_rd;
                logic [xlen-1:0]      data;
                logic                 redirect;
                logic [xlen-1:0]      redirect_pc;
        } exwb_t;

endpackage

`default_nettype wire

// ==== hw/exec_bus_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface exec_bus_if;
        import exec_pkg::*;

        // contents of the decode/execute register
        logic            valid;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] rs1_data;
        logic [xlen-1:0] rs2_data;
        alu_op_t         alu_op;
        src1_sel_t       src1_sel;
        src2_sel_t       src2_sel;
        br_cond_t        br_cond;

        modport src (
                output valid, pc, imm, rs1_data, rs2_data,
                output alu_op, src1_sel, src2_sel, br_cond
        );

        modport sink (
                input valid, pc, imm, rs1_data, rs2_data,
                input alu_op, src1_sel, src2_sel, br_cond
        );

endinterface

`default_nettype wire

// ==== hw/pipe_seg_reg.sv ====
`timescale 1ns/1ps
`default_nettype none

module pipe_seg_reg #(
        parameter type payload_t = exec_pkg::idex_t
) (
        input  logic     clk,
        input  logic     rst,
        input  logic     flush,
        input  logic     stall,
        input  payload_t d,
        output payload_t q
);
        import exec_pkg::*;

        payload_t bubble;

        // empty slot, pc parked at the reset vector
        always_comb begin
                bubble       = '0;
                bubble.valid = 1'b0;
                bubble.pc    = pc_rst;
        end

        // stall wins over flush
        always_ff @(posedge clk) begin
                if (rst || (flush && !stall)) begin
                        q <= bubble;
                end else if (!stall) begin
                        q <= d;
                end
        end

endmodule

`default_nettype wire

// ==== hw/operand_forward.sv ====
`timescale 1ns/1ps
`default_nettype none

module operand_forward (
        input  logic [exec_pkg::reg_idx_w-1:0] rs1,
        input  logic [exec_pkg::reg_idx_w-1:0] rs2,
        input  logic [exec_pkg::xlen-1:0]      rs1_data,
        input  logic [exec_pkg::xlen-1:0]      rs2_data,
        input  exec_pkg::exwb_t                ex_res,
        input  exec_pkg::exwb_t                wb_res,
        input  logic                           wb_write,
        input  logic [exec_pkg::reg_idx_w-1:0] wb_rd,
        input  logic [exec_pkg::xlen-1:0]      wb_data,
        output logic [exec_pkg::xlen-1:0]      fwd_rs1_data,
        output logic [exec_pkg::xlen-1:0]      fwd_rs2_data
);
        import exec_pkg::*;

        // newest producer first: execute, then ex_wb, then the wb port
        function automatic logic [xlen-1:0] pick(
                input logic [reg_idx_w-1:0] idx,
                input logic [xlen-1:0]      dec_data
        );
                logic [xlen-1:0] val;
                if (idx == '0) begin
                        // x0 is hardwired
                        val = dec_data;
                end else if (ex_res.valid && ex_res.write_rd && ex_res.rd == idx) begin
                        val = ex_res.data;
                end else if (wb_res.valid && wb_res.write_rd && wb_res.rd == idx) begin
                        val = wb_res.data;
                end else if (wb_write && wb_rd == idx) begin
                        val = wb_data;
                end else begin
                        val = dec_data;
                end
                return val;
        endfunction

        always_comb begin
                fwd_rs1_data = pick(rs1, rs1_data);
                fwd_rs2_data = pick(rs2, rs2_data);
        end

endmodule

`default_nettype wire

// ==== hw/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu_unit (
        exec_bus_if.sink                  bus,
        output logic [exec_pkg::xlen-1:0] alu_result
);
        import exec_pkg::*;

        logic [xlen-1:0] op_a;
        logic [xlen-1:0] op_b;
        logic [4:0]      shamt;
        logic            lt_s;
        logic            lt_u;

        // ==========================================================
        // operand select
        // ==========================================================
        always_comb begin
                if (bus.src1_sel == src1_pc) begin
                        op_a = bus.pc;
                end else begin
                        op_a = bus.rs1_data;
                end
        end

        // jumps select pc and four here, giving the link value
        always_comb begin
                case (bus.src2_sel)
                        src2_imm:  op_b = bus.imm;
                        src2_four: op_b = 32'd4;
                        default:   op_b = bus.rs2_data;
                endcase
        end

        assign shamt = op_b[4:0];
        assign lt_s  = $signed(op_a) < $signed(op_b);
        assign lt_u  = op_a < op_b;

        // ==========================================================
        // operations
        // ==========================================================
        always_comb begin
                case (bus.alu_op)
                        alu_sub:  alu_result = op_a - op_b;
                        alu_slt:  alu_result = xlen'(lt_s);
                        alu_sltu: alu_result = xlen'(lt_u);
                        alu_or:   alu_result = op_a | op_b;
                        alu_and:  alu_result = op_a & op_b;
                        alu_xor:  alu_result = op_a ^ op_b;
                        alu_sll:  alu_result = op_a << shamt;
                        alu_srl:  alu_result = op_a >> shamt;
                        alu_sra:  alu_result = $signed(op_a) >>> shamt;
                        default:  alu_result = op_a + op_b;
                endcase
        end

endmodule

`default_nettype wire

// ==== hw/branch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module branch_unit (
        exec_bus_if.sink                  bus,
        output logic                      taken,
        output logic [exec_pkg::xlen-1:0] target
);
        import exec_pkg::*;

        logic            eq;
        logic            lt_s;
        logic            lt_u;
        logic            cond;
        logic [xlen-1:0] jalr_sum;

        assign eq   = bus.rs1_data == bus.rs2_data;
        assign lt_s = $signed(bus.rs1_data) < $signed(bus.rs2_data);
        assign lt_u = bus.rs1_data < bus.rs2_data;

        // compare conditions
        always_comb begin
                case (bus.br_cond)
                        br_eq:   cond = eq;
                        br_ne:   cond = !eq;
                        br_lt:   cond = lt_s;
                        br_ge:   cond = !lt_s;
                        br_ltu:  cond = lt_u;
                        br_geu:  cond = !lt_u;
                        br_jal:  cond = 1'b1;
                        br_jalr: cond = 1'b1;
                        default: cond = 1'b0;
                endcase
        end

        // a bubble never redirects
        assign taken = bus.valid && cond;

        assign jalr_sum = bus.rs1_data + bus.imm;

        // jalr drops bit 0 of the sum
        assign target = (bus.br_cond == br_jalr) ? {jalr_sum[xlen-1:1], 1'b0}
                                                 : bus.pc + bus.imm;

endmodule

`default_nettype wire

// ==== hw/result_merge.sv ====
`timescale 1ns/1ps
`default_nettype none

module result_merge (
        input  exec_pkg::idex_t           ex_in,
        input  logic [exec_pkg::xlen-1:0] alu_result,
        input  logic                      taken,
        input  logic [exec_pkg::xlen-1:0] target,
        output exec_pkg::exwb_t           ex_res
);
        import exec_pkg::*;

        logic cond_branch;

        // jal and jalr still write the link register
        assign cond_branch = ex_in.br_cond inside {br_eq, br_ne, br_lt, br_ge, br_ltu, br_geu};

        always_comb begin
                ex_res.valid       = ex_in.valid;
                ex_res.pc          = ex_in.pc;
                ex_res.rd          = ex_in.rd;
                ex_res.write_rd    = ex_in.valid && ex_in.write_rd && !cond_branch;
                ex_res.data        = alu_result;
                ex_res.redirect    = ex_in.valid && taken;
                ex_res.redirect_pc = target;
        end

endmodule

`default_nettype wire

// ==== hw/exec_slice_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module exec_slice_top (
        input  logic                           clk,
        input  logic                           rst,
        input  logic                           stall,
        input  logic                           dec_valid,
        input  logic [exec_pkg::xlen-1:0]      dec_pc,
        input  logic [exec_pkg::reg_idx_w-1:0] dec_rd,
        input  logic [exec_pkg::reg_idx_w-1:0] dec_rs1,
        input  logic [exec_pkg::reg_idx_w-1:0] dec_rs2,
        input  logic                           dec_write_rd,
        input  logic [exec_pkg::xlen-1:0]      dec_imm,
        input  logic [exec_pkg::xlen-1:0]      dec_rs1_data,
        input  logic [exec_pkg::xlen-1:0]      dec_rs2_data,
        input  exec_pkg::alu_op_t              dec_alu_op,
        input  exec_pkg::src1_sel_t            dec_src1_sel,
        input  exec_pkg::src2_sel_t            dec_src2_sel,
        input  exec_pkg::br_cond_t             dec_br_cond,
        input  logic                           wb_write,
        input  logic [exec_pkg::reg_idx_w-1:0] wb_rd,
        input  logic [exec_pkg::xlen-1:0]      wb_data,
        output logic                           res_valid,
        output logic [exec_pkg::xlen-1:0]      res_pc,
        output logic [exec_pkg::reg_idx_w-1:0] res_rd,
        output logic                           res_write,
        output logic [exec_pkg::xlen-1:0]      res_data,
        output logic                           redirect_valid,
        output logic [exec_pkg::xlen-1:0]      redirect_pc
);
        import exec_pkg::*;

        logic [xlen-1:0] fwd_rs1_data;
        logic [xlen-1:0] fwd_rs2_data;
        logic [xlen-1:0] alu_result;
        logic [xlen-1:0] target;
        logic            taken;
        idex_t           id_ex_d;
        idex_t           id_ex_q;
        exwb_t           ex_res;
        exwb_t           wb_res;

        // ==========================================================
        // decode side, operands settled before id_ex
        // ==========================================================
        operand_forward u_fwd (
                .rs1          (dec_rs1),
                .rs2          (dec_rs2),
                .rs1_data     (dec_rs1_data),
                .rs2_data     (dec_rs2_data),
                .ex_res       (ex_res),
                .wb_res       (wb_res),
                .wb_write     (wb_write),
                .wb_rd        (wb_rd),
                .wb_data      (wb_data),
                .fwd_rs1_data (fwd_rs1_data),
                .fwd_rs2_data (fwd_rs2_data)
        );

        assign id_ex_d = '{valid: dec_valid, pc: dec_pc, rd: dec_rd,
                           write_rd: dec_write_rd, imm: dec_imm,
                           rs1_data: fwd_rs1_data, rs2_data: fwd_rs2_data,
                           alu_op: dec_alu_op, src1_sel: dec_src1_sel,
                           src2_sel: dec_src2_sel, br_cond: dec_br_cond};

        // taken branch squashes the incoming offer
        pipe_seg_reg #(.payload_t(idex_t)) id_ex (
                .clk   (clk),
                .rst   (rst),
                .flush (ex_res.redirect),
                .stall (stall),
                .d     (id_ex_d),
                .q     (id_ex_q)
        );

        // ==========================================================
        // execute
        // ==========================================================
        exec_bus_if bus ();

        assign bus.valid    = id_ex_q.valid;
        assign bus.pc       = id_ex_q.pc;
        assign bus.imm      = id_ex_q.imm;
        assign bus.rs1_data = id_ex_q.rs1_data;
        assign bus.rs2_data = id_ex_q.rs2_data;
        assign bus.alu_op   = id_ex_q.alu_op;
        assign bus.src1_sel = id_ex_q.src1_sel;
        assign bus.src2_sel = id_ex_q.src2_sel;
        assign bus.br_cond  = id_ex_q.br_cond;

        alu_unit u_alu (
                .bus        (bus.sink),
                .alu_result (alu_result)
        );

        branch_unit u_branch (
                .bus    (bus.sink),
                .taken  (taken),
                .target (target)
        );

        result_merge u_merge (
                .ex_in      (id_ex_q),
                .alu_result (alu_result),
                .taken      (taken),
                .target     (target),
                .ex_res     (ex_res)
        );

        // bubble into ex_wb while id_ex holds
        pipe_seg_reg #(.payload_t(exwb_t)) ex_wb (
                .clk   (clk),
                .rst   (rst),
                .flush (stall),
                .stall (1'b0),
                .d     (ex_res),
                .q     (wb_res)
        );

        assign res_valid      = wb_res.valid;
        assign res_pc         = wb_res.pc;
        assign res_rd         = wb_res.rd;
        assign res_write      = wb_res.write_rd;
        assign res_data       = wb_res.data;
        assign redirect_valid = wb_res.redirect;
        assign redirect_pc    = wb_res.redirect_pc;

endmodule

`default_nettype wire

// ==== verification/tb_exec_slice.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_exec_slice;
        import exec_pkg::*;

        localparam int fields     = 24;
        localparam int exp_col    = 17;
        localparam int max_vecs   = 128;
        localparam int clk_period = 4;
        localparam int rst_cycles = 16;
        localparam logic [31:0] reset_pc = 32'h8000_0000;

        logic                 clk;
        logic                 rst;
        logic                 stall;
        logic                 dec_valid;
        logic [xlen-1:0]      dec_pc;
        logic [reg_idx_w-1:0] dec_rd;
        logic [reg_idx_w-1:0] dec_rs1;
        logic [reg_idx_w-1:0] dec_rs2;
        logic                 dec_write_rd;
        logic [xlen-1:0]      dec_imm;
        logic [xlen-1:0]      dec_rs1_data;
        logic [xlen-1:0]      dec_rs2_data;
        alu_op_t              dec_alu_op;
        src1_sel_t            dec_src1_sel;
        src2_sel_t            dec_src2_sel;
        br_cond_t             dec_br_cond;
        logic                 wb_write;
        logic [reg_idx_w-1:0] wb_rd;
        logic [xlen-1:0]      wb_data;
        logic                 res_valid;
        logic [xlen-1:0]      res_pc;
        logic [reg_idx_w-1:0] res_rd;
        logic                 res_write;
        logic [xlen-1:0]      res_data;
        logic                 redirect_valid;
        logic [xlen-1:0]      redirect_pc;

        // one line of the input file is 24 words
        logic [31:0] vec_mem [0:fields*max_vecs-1];
        int          vec_count;
        logic        vec_loaded;
        int          errors;
        int          checks;

        // pc expected in id_ex and in ex_wb
        logic [31:0] pc_in_id;
        logic [31:0] pc_in_ex;

        exec_slice_top UUT (
                .clk            (clk),
                .rst            (rst),
                .stall          (stall),
                .dec_valid      (dec_valid),
                .dec_pc         (dec_pc),
                .dec_rd         (dec_rd),
                .dec_rs1        (dec_rs1),
                .dec_rs2        (dec_rs2),
                .dec_write_rd   (dec_write_rd),
                .dec_imm        (dec_imm),
                .dec_rs1_data   (dec_rs1_data),
                .dec_rs2_data   (dec_rs2_data),
                .dec_alu_op     (dec_alu_op),
                .dec_src1_sel   (dec_src1_sel),
                .dec_src2_sel   (dec_src2_sel),
                .dec_br_cond    (dec_br_cond),
                .wb_write       (wb_write),
                .wb_rd          (wb_rd),
                .wb_data        (wb_data),
                .res_valid      (res_valid),
                .res_pc         (res_pc),
                .res_rd         (res_rd),
                .res_write      (res_write),
                .res_data       (res_data),
                .redirect_valid (redirect_valid),
                .redirect_pc    (redirect_pc)
        );

        initial begin
                clk = 1'b0;
                forever #(clk_period / 2) clk = ~clk;
        end

        // ==========================================================
        // helpers
        // ==========================================================
        task automatic compare_field(input string name, input int idx,
                                     input logic [31:0] expected, input logic [31:0] actual);
                checks++;
                assert (actual === expected) else begin
                        errors++;
                        $display("error: %s expected %h actual %h (vector %0d)",
                                 name, expected, actual, idx);
                end
        endtask

        task automatic drive_idle();
                stall        = 1'b0;
                dec_valid    = 1'b0;
                dec_pc       = '0;
                dec_rd       = '0;
                dec_rs1      = '0;
                dec_rs2      = '0;
                dec_write_rd = 1'b0;
                dec_imm      = '0;
                dec_rs1_data = '0;
                dec_rs2_data = '0;
                dec_alu_op   = alu_add;
                dec_src1_sel = src1_rs1;
                dec_src2_sel = src2_rs2;
                dec_br_cond  = br_none;
                wb_write     = 1'b0;
                wb_rd        = '0;
                wb_data      = '0;
        endtask

        task automatic apply_line(input int idx);
                int base;
                base = idx * fields;
                stall        = vec_mem[base][0];
                dec_valid    = vec_mem[base + 1][0];
                dec_pc       = vec_mem[base + 2];
                dec_rd       = vec_mem[base + 3][reg_idx_w-1:0];
                dec_rs1      = vec_mem[base + 4][reg_idx_w-1:0];
                dec_rs2      = vec_mem[base + 5][reg_idx_w-1:0];
                dec_write_rd = vec_mem[base + 6][0];
                dec_imm      = vec_mem[base + 7];
                dec_rs1_data = vec_mem[base + 8];
                dec_rs2_data = vec_mem[base + 9];
                dec_alu_op   = alu_op_t'(vec_mem[base + 10][3:0]);
                dec_src1_sel = src1_sel_t'(vec_mem[base + 11][0]);
                dec_src2_sel = src2_sel_t'(vec_mem[base + 12][1:0]);
                dec_br_cond  = br_cond_t'(vec_mem[base + 13][3:0]);
                wb_write     = vec_mem[base + 14][0];
                wb_rd        = vec_mem[base + 15][reg_idx_w-1:0];
                wb_data      = vec_mem[base + 16];
        endtask

        // an offer reaches id_ex only on an edge without stall
        task automatic track_pc();
                if (!stall) begin
                        pc_in_ex = pc_in_id;
                        pc_in_id = dec_pc;
                end
        endtask

        // rd and data only matter for a valid slot
        task automatic check_line(input int idx);
                int base;
                base = idx * fields + exp_col;
                if (vec_mem[base][0]) begin
                        compare_field("res_valid", idx, vec_mem[base + 1], res_valid);
                        compare_field("res_write", idx, vec_mem[base + 3], res_write);
                        compare_field("redirect_valid", idx, vec_mem[base + 5], redirect_valid);
                        if (vec_mem[base + 1][0]) begin
                                compare_field("res_rd", idx, vec_mem[base + 2], res_rd);
                                compare_field("res_data", idx, vec_mem[base + 4], res_data);
                                compare_field("res_pc", idx, pc_in_ex, res_pc);
                        end
                        if (vec_mem[base + 5][0]) begin
                                compare_field("redirect_pc", idx, vec_mem[base + 6], redirect_pc);
                        end
                end
        endtask

        task automatic check_empty_outputs(input int idx);
                compare_field("res_valid", idx, 32'h0, res_valid);
                compare_field("res_write", idx, 32'h0, res_write);
                compare_field("redirect_valid", idx, 32'h0, redirect_valid);
                compare_field("res_pc", idx, reset_pc, res_pc);
        endtask

        // ==========================================================
        // main sequence
        // ==========================================================
        initial begin
                errors     = 0;
                checks     = 0;
                vec_count  = 0;
                vec_loaded = 1'b0;
                pc_in_id   = reset_pc;
                pc_in_ex   = reset_pc;
                rst        = 1'b1;
                drive_idle();
                $readmemh("verification/exec_slice_input.txt", vec_mem);
                while (vec_count < max_vecs && !$isunknown(vec_mem[vec_count * fields])) begin
                        vec_count++;
                end
                vec_loaded = 1'b1;
                if (vec_count == 0) begin
                        errors++;
                        $display("no stimulus vectors could be read from the input file");
                end

                // outputs stay empty while reset is held
                repeat (rst_cycles) begin
                        @(posedge clk);
                        #1;
                        check_empty_outputs(-1);
                end

                for (int i = 0; i < vec_count; i++) begin
                        @(negedge clk);
                        rst = 1'b0;
                        apply_line(i);
                        track_pc();
                        @(posedge clk);
                        #1;
                        if (i == 0) begin
                                check_empty_outputs(0);
                        end else begin
                                check_line(i - 1);
                        end
                end

                // drain the last result
                @(negedge clk);
                drive_idle();
                track_pc();
                @(posedge clk);
                #1;
                if (vec_count > 0) begin
                        check_line(vec_count - 1);
                end

                $display("vectors %0d, checks %0d, errors %0d", vec_count, checks, errors);
                if (errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

        // watchdog, sized from the vector count
        initial begin
                int run_limit;
                wait (vec_loaded);
                run_limit = vec_count * clk_period + rst_cycles * clk_period + 200;
                #(run_limit);
                $display("timeout: the run did not finish within %0d ns", run_limit);
                $display("sim failed");
                $finish;
        end

endmodule

`default_nettype wire

// ==== list.f ====
hw/exec_pkg.sv
hw/exec_bus_if.sv
hw/pipe_seg_reg.sv
hw/operand_forward.sv
hw/alu_unit.sv
hw/branch_unit.sv
hw/result_merge.sv
hw/exec_slice_top.sv
verification/tb_exec_slice.sv

// ==== verification/exec_slice_input.txt ====
// stall valid pc rd rs1 rs2 write_rd imm rs1_data rs2_data alu_op src1 src2 br wb_write wb_rd wb_data
// then check valid rd write data redirect redirect_pc, outputs one edge after this line's edge
0 0 100 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0
// alu operations and operand selects
0 1 104 1 10 11 1 0 7fffffff 1 0 0 0 0 0 0 0  1 1 1 1 80000000 0 0
0 1 108 2 10 11 1 0 5 7 1 0 0 0 0 0 0  1 1 2 1 fffffffe 0 0
0 1 10c 3 10 11 1 0 ffffffff 1 2 0 0 0 0 0 0  1 1 3 1 1 0 0
0 1 110 4 10 11 1 0 ffffffff 1 3 0 0 0 0 0 0  1 1 4 1 0 0 0
0 1 114 5 10 11 1 f0 f00f 0 4 0 1 0 0 0 0  1 1 5 1 f0ff 0 0
0 1 118 6 10 11 1 ffff0000 12345678 0 5 0 1 0 0 0 0  1 1 6 1 12340000 0 0
0 1 11c 7 10 11 1 0 aaaa5555 ffff0000 6 0 0 0 0 0 0  1 1 7 1 55555555 0 0
0 1 120 8 10 11 1 0 1 24 7 0 0 0 0 0 0  1 1 8 1 10 0 0
0 1 124 9 10 11 1 1f 80000000 0 8 0 1 0 0 0 0  1 1 9 1 1 0 0
0 1 128 a 10 11 1 0 80000000 1f 9 0 0 0 0 0 0  1 1 a 1 ffffffff 0 0
0 1 12c b 10 11 1 0 40000000 2 9 0 0 0 0 0 0  1 1 b 1 10000000 0 0
0 1 130 c 10 11 1 1000 0 0 0 1 1 0 0 0 0  1 1 c 1 1130 0 0
0 1 134 d 10 11 1 fffffff0 5 0 2 0 1 0 0 0 0  1 1 d 1 0 0 0
0 1 138 e 10 11 1 fffffff0 5 0 3 0 1 0 0 0 0  1 1 e 1 1 0 0
0 1 13c f 10 11 1 0 0 3c 1 1 0 0 0 0 0  1 1 f 1 100 0 0
// forwarding from execute, ex_wb, the wb port, priority and x0
0 1 140 5 10 11 1 0 100 23 0 0 0 0 0 0 0  1 1 5 1 123 0 0
0 1 144 6 5 11 1 0 dead 1 0 0 0 0 0 0 0  1 1 6 1 124 0 0
0 1 148 7 10 11 1 0 0 0 0 0 0 0 0 0 0  1 1 7 1 0 0 0
0 1 14c 8 10 6 1 0 1 bad 0 0 0 0 0 0 0  1 1 8 1 125 0 0
0 1 150 9 10 11 1 0 0 0 0 0 0 0 0 0 0  1 1 9 1 0 0 0
0 1 154 a 10 11 1 0 0 0 0 0 0 0 0 0 0  1 1 a 1 0 0 0
0 1 158 13 12 11 1 0 bad 1 0 0 0 0 1 12 777  1 1 13 1 778 0 0
0 1 15c 13 10 11 1 0 20 0 0 0 0 0 0 0 0  1 1 13 1 20 0 0
0 1 160 14 11 13 1 0 3 bad 1 0 0 0 1 13 999  1 1 14 1 ffffffe3 0 0
0 1 164 15 13 11 1 0 bad 100 4 0 0 0 1 13 999  1 1 15 1 120 0 0
0 1 168 0 10 11 1 0 55 0 0 0 0 0 0 0 0  1 1 0 1 55 0 0
0 1 16c 16 0 0 1 0 3 4 0 0 0 0 1 0 aaa  1 1 16 1 7 0 0
// branches, each taken one squashes the next offer
0 1 170 1 10 11 1 40 5 5 0 0 0 1 0 0 0  1 1 1 0 a 1 1b0
0 1 174 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 178 0 10 11 0 40 5 6 0 0 0 1 0 0 0  1 1 0 0 b 0 0
0 1 17c 0 10 11 0 fffffff0 5 6 0 0 0 2 0 0 0  1 1 0 0 b 1 16c
0 1 180 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 184 0 10 11 0 40 9 9 0 0 0 2 0 0 0  1 1 0 0 12 0 0
0 1 188 0 10 11 0 8 ffffffff 1 0 0 0 3 0 0 0  1 1 0 0 0 1 190
0 1 18c 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 190 0 10 11 0 8 1 ffffffff 0 0 0 3 0 0 0  1 1 0 0 0 0 0
0 1 194 0 10 11 0 20 1 ffffffff 0 0 0 4 0 0 0  1 1 0 0 0 1 1b4
0 1 198 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 19c 0 10 11 0 20 ffffffff 1 0 0 0 4 0 0 0  1 1 0 0 0 0 0
0 1 1a0 0 10 11 0 10 1 ffffffff 0 0 0 5 0 0 0  1 1 0 0 0 1 1b0
0 1 1a4 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 1a8 0 10 11 0 10 ffffffff 1 0 0 0 5 0 0 0  1 1 0 0 0 0 0
0 1 1ac 0 10 11 0 4 ffffffff 1 0 0 0 6 0 0 0  1 1 0 0 0 1 1b0
0 1 1b0 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 1b4 0 10 11 0 4 1 ffffffff 0 0 0 6 0 0 0  1 1 0 0 0 0 0
0 1 1b8 1 10 11 1 100 0 0 0 1 2 7 0 0 0  1 1 1 1 1bc 1 2b8
0 1 1bc 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 1c0 2 10 11 1 22 1001 0 0 1 2 8 0 0 0  1 1 2 1 1c4 1 1022
0 1 1c4 2 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
// stall, then a taken branch held by a stall
0 1 1c8 3 10 11 1 0 10 20 0 0 0 0 0 0 0  1 0 0 0 0 0 0
1 1 1cc 4 10 11 1 0 1 1 0 0 0 0 0 0 0  1 0 0 0 0 0 0
1 1 1cc 4 10 11 1 0 1 1 0 0 0 0 0 0 0  1 1 3 1 30 0 0
0 1 1cc 4 10 11 1 0 1 1 0 0 0 0 0 0 0  1 1 4 1 2 0 0
0 0 1d0 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 1d0 0 10 11 0 30 0 0 0 0 0 1 0 0 0  1 0 0 0 0 0 0
1 1 1d4 6 10 11 1 0 7 8 0 0 0 0 0 0 0  1 1 0 0 0 1 200
0 1 1d4 6 10 11 1 0 7 8 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 1 200 7 10 11 1 0 1 2 0 0 0 0 0 0 0  1 1 7 1 3 0 0
0 0 204 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0
0 0 208 0 0 0 0 0 0 0 0 0 0 0 0 0 0  1 0 0 0 0 0 0
